// ==== avg_pkg.sv ====
package avg_pkg;

	// ========================================
	// widths
	// ========================================

	// raw sample and mean width
	localparam int SAMPLE_W = 8;
	// window length counter, 15 samples max
	localparam int COUNT_W = 4;
	// sum of up to 15 full-scale samples
	localparam int SUM_W = 12;
	// divider runs at the sum width
	localparam int DIV_W = SUM_W;
	// iteration index, must hold DIV_W + 1
	localparam int DIV_IDX_W = 4;

	// ========================================
	// vector types
	// ========================================

	typedef logic [SAMPLE_W-1:0]  sample_t;
	typedef logic [COUNT_W-1:0]   count_t;
	typedef logic [SUM_W-1:0]     sum_t;
	typedef logic [DIV_IDX_W-1:0] div_idx_t;

	// divider fsm
	typedef enum logic [1:0]
	{
		st_idle,
		st_op,
		st_last,
		st_done
	} div_state_t;

	// ========================================
	// stage payloads
	// ========================================

	// accumulator to divider
	typedef struct packed
	{
		sum_t   sum;
		count_t count;
	} div_req_t;

	// divider to rounding stage, count rides along as sideband
	typedef struct packed
	{
		sum_t   quo;
		sum_t   rmd;
		count_t count;
	} div_res_t;

	// final mean
	typedef struct packed
	{
		sample_t mean;
		count_t  count;
	} mean_res_t;

endpackage

// ==== sample_accum.sv ====
`timescale 1ns/1ps

module sample_accum
	import avg_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     sample_valid,
	input  sample_t  sample,
	input  logic     window_close,
	input  logic     div_ready,
	output logic     req_valid,
	output div_req_t div_req,
	output logic     overrun
);

	// running window state
	sum_t   sum_reg;
	count_t count_reg;
	// window state including this cycle's sample
	sum_t   sum_now;
	count_t count_now;
	logic   take;
	logic   non_empty;
	logic   load;

	// ========================================
	// sample intake
	// ========================================

	always_comb
	begin
		// refuse samples once 15 are held
		take = sample_valid && (count_reg != {COUNT_W{1'b1}});
		sum_now = sum_reg;
		count_now = count_reg;
		if (take)
		begin
			sum_now = sum_reg + SUM_W'(sample);
			count_now = count_reg + 1'b1;
		end
		// a same-cycle sample belongs to the closing window
		non_empty = (count_now != '0);
		// slot free, so the window becomes the pending request
		load = window_close && non_empty && !req_valid;
	end

	// ========================================
	// window and request control
	// ========================================

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sum_reg <= '0;
			count_reg <= '0;
			req_valid <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			// slot still busy, this window is dropped
			overrun <= window_close && non_empty && req_valid;
			// restart from zero after any close
			if (window_close)
			begin
				sum_reg <= '0;
				count_reg <= '0;
			end
			else
			begin
				sum_reg <= sum_now;
				count_reg <= count_now;
			end
			// hold until the divider takes it
			if (load)
				req_valid <= 1'b1;
			else if (req_valid && div_ready)
				req_valid <= 1'b0;
		end
	end

	// pending request payload
	always_ff @(posedge clk)
	begin
		if (load)
			div_req <= '{sum: sum_now, count: count_now};
	end

endmodule

// ==== seq_divider.sv ====
`timescale 1ns/1ps

module seq_divider
	import avg_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  div_req_t div_req,
	output logic     ready,
	output logic     done_tick,
	output div_res_t div_res
);

	div_state_t state_reg;
	// partial remainder in the high half of the shift pair
	sum_t       rh_reg;
	// takes the dividend and collects quotient bits
	sum_t       rl_reg;
	sum_t       d_reg;
	// sample count kept for the rounding stage
	count_t     cnt_reg;
	div_idx_t   n_reg;
	div_idx_t   n_next;
	sum_t       rh_tmp;
	logic       q_bit;

	// ========================================
	// compare and subtract
	// ========================================

	always_comb
	begin
		if (rh_reg >= d_reg)
		begin
			rh_tmp = rh_reg - d_reg;
			q_bit = 1'b1;
		end
		else
		begin
			rh_tmp = rh_reg;
			q_bit = 1'b0;
		end
		// index counts down toward last
		n_next = n_reg - 1'b1;
	end

	// ========================================
	// fsm and index
	// ========================================

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_reg <= st_idle;
			n_reg <= '0;
		end
		else
		begin
			case (state_reg)
				st_idle:
				begin
					if (start)
					begin
						// first op step only brings in the dividend msb
						n_reg <= DIV_IDX_W'(DIV_W + 1);
						state_reg <= st_op;
					end
				end
				st_op:
				begin
					n_reg <= n_next;
					if (n_next == div_idx_t'(1))
						state_reg <= st_last;
				end
				st_last:
					state_reg <= st_done;
				st_done:
					state_reg <= st_idle;
				default:
					state_reg <= st_idle;
			endcase
		end
	end

	// ========================================
	// datapath
	// ========================================

	always_ff @(posedge clk)
	begin
		case (state_reg)
			st_idle:
			begin
				if (start)
				begin
					rh_reg <= '0;
					rl_reg <= div_req.sum;
					// count zero-extended as divisor
					d_reg <= SUM_W'(div_req.count);
					cnt_reg <= div_req.count;
				end
			end
			st_op:
			begin
				// pair shifts left as the quotient bit enters at the bottom
				rl_reg <= {rl_reg[DIV_W-2:0], q_bit};
				rh_reg <= {rh_tmp[DIV_W-2:0], rl_reg[DIV_W-1]};
			end
			st_last:
			begin
				// final compare with no dividend bits left to pull in
				rl_reg <= {rl_reg[DIV_W-2:0], q_bit};
				rh_reg <= rh_tmp;
			end
			default:
				;
		endcase
	end

	// handshake is straight from the state
	assign ready = (state_reg == st_idle);
	assign done_tick = (state_reg == st_done);
	assign div_res = '{quo: rl_reg, rmd: rh_reg, count: cnt_reg};

endmodule

// ==== mean_round.sv ====
`timescale 1ns/1ps

module mean_round
	import avg_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      div_done,
	input  div_res_t  div_res,
	output logic      result_valid,
	output mean_res_t result
);

	logic round_up;
	sum_t mean_wide;

	// ========================================
	// round half up
	// ========================================

	always_comb
	begin
		// 2*rmd >= count, one extra bit so the doubling cannot wrap
		round_up = {div_res.rmd, 1'b0} >= (SUM_W + 1)'(div_res.count);
		mean_wide = div_res.quo + SUM_W'(round_up);
	end

	// strobe follows div_done by one edge
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= div_done;
	end

	// mean of 8-bit samples never exceeds 255, low byte is enough
	always_ff @(posedge clk)
	begin
		if (div_done)
			result <= '{mean: mean_wide[SAMPLE_W-1:0], count: div_res.count};
	end

endmodule

// ==== mean_unit.sv ====
`timescale 1ns/1ps

module mean_unit
	import avg_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      sample_valid,
	input  sample_t   sample,
	input  logic      window_close,
	output logic      result_valid,
	output mean_res_t result,
	output logic      overrun
);

	// accumulator to divider
	logic     req_valid;
	logic     div_ready;
	div_req_t div_req;
	// divider to rounding
	logic     div_done;
	div_res_t div_res;

	// windows in, one pending request out
	sample_accum u_accum (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.window_close (window_close),
		.div_ready    (div_ready),
		.req_valid    (req_valid),
		.div_req      (div_req),
		.overrun      (overrun)
	);

	// sum / count, one bit per clock
	seq_divider u_div (
		.clk       (clk),
		.reset     (reset),
		.start     (req_valid),
		.div_req   (div_req),
		.ready     (div_ready),
		.done_tick (div_done),
		.div_res   (div_res)
	);

	// nearest-integer mean
	mean_round u_round (
		.clk          (clk),
		.reset        (reset),
		.div_done     (div_done),
		.div_res      (div_res),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

// ==== tb_mean_unit.sv ====
`timescale 1ns/1ps

module tb_mean_unit
	import avg_pkg::*;
();

	// ========================================
	// run length
	// ========================================

	localparam int CLK_PERIOD = 100;
	localparam int MAX_COUNT = (1 << COUNT_W) - 1;
	localparam int NUM_RAND_WIN = 40;
	// plus rounding, extreme, empty, overrun and overflow windows
	localparam int NUM_WINDOWS = NUM_RAND_WIN + 30;
	// 18 samples with idle gaps, close, spacing
	localparam int WIN_CYCLES = 65;
	localparam int DRAIN_CYCLES = 40;
	localparam int TEST_CYCLES = NUM_WINDOWS * WIN_CYCLES + DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 2 + 1000;

	logic      clk = 1'b0;
	logic      reset;
	logic      sample_valid;
	sample_t   sample;
	logic      window_close;
	logic      result_valid;
	mean_res_t result;
	logic      overrun;

	logic [31:0] rng_state = 32'hfb832373;
	sample_t     win_buf [0:19];
	string       test_name = "reset";
	int          value_errors = 0;
	int          other_errors = 0;
	int          results_checked = 0;
	int          overrun_pulses = 0;

	// reference model state
	mean_res_t exp_q [$];
	mean_res_t exp_res;
	int        m_sum = 0;
	int        m_cnt = 0;
	int        m_busy = 0;
	logic      m_pend = 1'b0;
	logic      m_xfer;
	logic      m_load;
	logic      exp_ovr = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	mean_unit u_dut (
		.clk          (clk),
		.reset        (reset),
		.sample_valid (sample_valid),
		.sample       (sample),
		.window_close (window_close),
		.result_valid (result_valid),
		.result       (result),
		.overrun      (overrun)
	);

	// ========================================
	// helpers
	// ========================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		return int'(rand32() % 32'(n));
	endfunction

	// nearest mean, half rounds up
	function automatic mean_res_t expected_mean(input int sum, input int cnt);
		int        q;
		int        r;
		mean_res_t res;
		q = sum / cnt;
		r = sum % cnt;
		if (2 * r >= cnt)
			q = q + 1;
		res.mean = sample_t'(q);
		res.count = count_t'(cnt);
		return res;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (act_v !== exp_v)
		begin
			value_errors++;
			$display("ERR %s expected %0d actual %0d", name, exp_v, act_v);
		end
	endtask

	// inputs change on the falling edge only
	task automatic step(input logic sv, input sample_t s, input logic wc);
		@(negedge clk);
		sample_valid = sv;
		sample = s;
		window_close = wc;
	endtask

	// n-1 copies of base, last one carries the remainder
	task automatic fill_window(input int n, input int base, input int extra);
		int i;
		for (i = 0; i < n - 1; i++)
			win_buf[i] = sample_t'(base);
		win_buf[n - 1] = sample_t'(base + extra);
	endtask

	task automatic play_window(input int n);
		logic close_last;
		int   i;
		// close sometimes lands on the last sample
		close_last = (n > 0) && (rand_below(2) == 1);
		for (i = 0; i < n; i++)
		begin
			step(1'b1, win_buf[i], close_last && (i == n - 1));
			if (rand_below(4) == 0)
				step(1'b0, '0, 1'b0);
		end
		if (!close_last)
			step(1'b0, '0, 1'b1);
		// at least 20 cycles to the next close
		repeat (20 + rand_below(8))
			step(1'b0, '0, 1'b0);
	endtask

	// ========================================
	// reference model
	// ========================================

	always @(posedge clk)
	begin
		if (reset)
		begin
			m_sum = 0;
			m_cnt = 0;
			m_busy = 0;
			m_pend = 1'b0;
			exp_ovr = 1'b0;
		end
		else
		begin
			// sample on the closing edge still counts, 16th and later dropped
			if (sample_valid && m_cnt < MAX_COUNT)
			begin
				m_sum = m_sum + int'(sample);
				m_cnt = m_cnt + 1;
			end
			m_xfer = m_pend && (m_busy == 0);
			m_load = window_close && (m_cnt > 0) && !m_pend;
			exp_ovr = window_close && (m_cnt > 0) && m_pend;
			if (m_load)
				exp_q.push_back(expected_mean(m_sum, m_cnt));
			if (window_close)
			begin
				m_sum = 0;
				m_cnt = 0;
			end
			// divider busy through op, last and done
			if (m_xfer)
				m_busy = DIV_W + 2;
			else if (m_busy > 0)
				m_busy = m_busy - 1;
			if (m_load)
				m_pend = 1'b1;
			else if (m_xfer)
				m_pend = 1'b0;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (!reset)
		begin
			check_val({test_name, " overrun"}, 32'(exp_ovr), 32'(overrun));
			if (overrun)
				overrun_pulses++;
			if (result_valid)
			begin
				if (exp_q.size() == 0)
				begin
					other_errors++;
					$display("%s: result_valid with no window waiting for a result", test_name);
				end
				else
				begin
					exp_res = exp_q.pop_front();
					check_val({test_name, " mean"}, 32'(exp_res.mean), 32'(result.mean));
					check_val({test_name, " count"}, 32'(exp_res.count), 32'(result.count));
					results_checked++;
				end
			end
		end
	end

	// ========================================
	// stimulus
	// ========================================

	initial
	begin
		int n;
		int i;
		int base;
		reset = 1'b1;
		sample_valid = 1'b0;
		sample = '0;
		window_close = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_name = "random";
		repeat (NUM_RAND_WIN)
		begin
			n = 1 + rand_below(MAX_COUNT);
			for (i = 0; i < n; i++)
				win_buf[i] = sample_t'(rand32());
			play_window(n);
		end

		test_name = "round";
		for (n = 2; n <= MAX_COUNT; n++)
		begin
			base = rand_below(240);
			// remainder exactly half
			if (n % 2 == 0)
			begin
				fill_window(n, base, n / 2);
				play_window(n);
			end
			// just under half
			fill_window(n, base, (n - 1) / 2);
			play_window(n);
		end

		test_name = "extreme";
		fill_window(MAX_COUNT, 255, 0);
		play_window(MAX_COUNT);
		fill_window(MAX_COUNT, 0, 0);
		play_window(MAX_COUNT);
		fill_window(1, rand_below(256), 0);
		play_window(1);

		test_name = "empty";
		play_window(0);

		test_name = "overrun";
		for (i = 0; i < 4; i++)
			step(1'b1, sample_t'(rand32()), 1'b0);
		step(1'b0, '0, 1'b1);
		// divider now busy, next window waits in the slot
		repeat (3)
			step(1'b0, '0, 1'b0);
		step(1'b1, sample_t'(rand32()), 1'b1);
		step(1'b1, sample_t'(rand32()), 1'b0);
		// slot still full two cycles later
		step(1'b0, '0, 1'b1);
		repeat (40)
			step(1'b0, '0, 1'b0);

		test_name = "overflow";
		for (i = 0; i < 18; i++)
			win_buf[i] = sample_t'(rand32());
		play_window(18);

		test_name = "drain";
		repeat (DRAIN_CYCLES)
			step(1'b0, '0, 1'b0);
		if (exp_q.size() != 0)
		begin
			other_errors++;
			$display("%0d expected results never appeared on result_valid", exp_q.size());
		end
		check_val("overrun pulses", 32'd1, 32'(overrun_pulses));
		$display("summary: %0d results checked, %0d value errors, %0d other errors",
			results_checked, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
avg_pkg.sv
sample_accum.sv
seq_divider.sv
mean_round.sv
mean_unit.sv
tb_mean_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mean unit testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_mean_unit
log=sim.log

verilator --binary --timing -f flist.f --top-module "$top"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
